/* design/sbusPkg.sv */
/*
 * Storage bus widths for the quadword read port
 * Word, address, request mask and word offset sizes
 */
`default_nettype none

package sbusPkg;

  // One PDP-10 word plus no tag bits on the data bus
  localparam int wordBits = 36;

  // Word address carried on the bus during START
  localparam int adrBits = 22;

  // Request mask, one bit per word of a quadword
  localparam int rqBits = 4;

  // Word offset inside a quadword, steps modulo 4
  localparam int offBits = 2;

endpackage : sbusPkg

`default_nettype wire

/* design/coreMemPkg.sv */
/*
 * Installed core memory sizes
 * Word count, array index width and quadword base width
 */
`default_nettype none

package coreMemPkg;

  localparam int memWords = 4096;               // Words of installed core
  localparam int indexBits = $clog2(memWords);  // Array index, 12 bits

  // Index bits above the word offset select the quadword
  localparam int quadBits = indexBits - sbusPkg::offBits;

endpackage : coreMemPkg

`default_nettype wire

/* design/quadDecode.sv */
/*
 * Per-phase START decode with address range check
 * Captures quadword base, start offset and request mask
 */
`timescale 1ns/1ns
`default_nettype none

module quadDecode #(
  parameter bit servesB = 1'b0                  // 0 serves A phase, 1 serves B phase
) (
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire logic                              sbusClkInt,
  input  wire logic                              start,
  input  wire logic [sbusPkg::adrBits-1:0]       adr,
  input  wire logic [sbusPkg::rqBits-1:0]        rq,
  output logic                                   accept,
  output logic      [coreMemPkg::quadBits-1:0]   quadBase,
  output logic      [sbusPkg::offBits-1:0]       startOff,
  output logic      [sbusPkg::rqBits-1:0]        mask
);

  logic ourPhase;                                // Current cycle belongs to this decoder
  logic inRange;                                 // Address lies in installed core
  logic take;                                    // START answered this cycle

  assign ourPhase = (sbusClkInt == servesB);

  // Nonexistent memory stays silent, so high address bits must be zero
  assign inRange = (adr[sbusPkg::adrBits-1:coreMemPkg::indexBits] == '0);

  assign take = start && ourPhase && inRange;

  // Accept pulse lasts one clock after the START cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      accept <= 1'b0;
    end else begin
      accept <= take;
    end
  end

  // Request fields are held until the next accepted START
  always_ff @(posedge clk) begin
    if (take) begin
      quadBase <= adr[coreMemPkg::indexBits-1:sbusPkg::offBits];  // Quadword base
      startOff <= adr[sbusPkg::offBits-1:0];                      // First word offset
      mask     <= rq;                                             // Words wanted
    end
  end

endmodule : quadDecode

`default_nettype wire

/* design/quadSequencer.sv */
/*
 * Quadword read sequencer for one bus phase
 * Steps the request mask and wraps the word offset modulo 4
 */
`timescale 1ns/1ns
`default_nettype none

module quadSequencer #(
  parameter bit servesB = 1'b0                  // Must match the paired decoder
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst,
  input  wire logic                                 sbusClkInt,
  input  wire logic                                 accept,
  input  wire logic [coreMemPkg::quadBits-1:0]      quadBase,
  input  wire logic [sbusPkg::offBits-1:0]          startOff,
  input  wire logic [sbusPkg::rqBits-1:0]           mask,
  output logic      [coreMemPkg::indexBits-1:0]     readIndex,
  output logic                                      rawAck
);

  logic [sbusPkg::rqBits-1:0]       toAck;      // Mask positions not yet presented
  logic [sbusPkg::offBits-1:0]      wordOff;    // Offset of the word being presented
  logic [coreMemPkg::quadBits-1:0]  base;       // Quadword being read
  logic                             ownEdge;    // Clock edge ends a cycle of our phase
  logic                             busy;       // Some mask positions still pending

  assign ownEdge = (sbusClkInt == servesB);
  assign busy    = (toAck != '0);

  // Bit 0 of the remaining mask is the position shown this phase cycle
  assign rawAck    = toAck[0];
  assign readIndex = {base, wordOff};

  // A fresh accept restarts the sequence, even over pending words
  always_ff @(posedge clk) begin
    if (rst) begin
      toAck   <= '0;
      wordOff <= '0;
    end else if (accept) begin
      toAck   <= mask;
      wordOff <= startOff;
    end else if (ownEdge && busy) begin
      toAck   <= toAck >> 1;                     // Cleared positions still use a cycle
      wordOff <= wordOff + 1'b1;                 // Wraps inside the quadword
    end
  end

  // Base is only meaningful while toAck is nonzero
  always_ff @(posedge clk) begin
    if (accept) begin
      base <= quadBase;
    end
  end

endmodule : quadSequencer

`default_nettype wire

/* design/coreArray.sv */
/*
 * Core word storage
 * Two combinational read ports and one load write port
 */
`timescale 1ns/1ns
`default_nettype none

module coreArray (
  input  wire logic                                clk,
  input  wire logic [coreMemPkg::indexBits-1:0]    readIndexA,
  input  wire logic [coreMemPkg::indexBits-1:0]    readIndexB,
  input  wire logic                                loadEn,
  input  wire logic [coreMemPkg::indexBits-1:0]    loadAddr,
  input  wire logic [sbusPkg::wordBits-1:0]        loadData,
  output logic      [sbusPkg::wordBits-1:0]        wordA,
  output logic      [sbusPkg::wordBits-1:0]        wordB
);

  // Core keeps its contents through reset
  logic [sbusPkg::wordBits-1:0] mem [coreMemPkg::memWords];

  // Host style backdoor fill
  always_ff @(posedge clk) begin
    if (loadEn) begin
      mem[loadAddr] <= loadData;                 // Same cycle reads see the old word
    end
  end

  assign wordA = mem[readIndexA];                // A phase word
  assign wordB = mem[readIndexB];                // B phase word

endmodule : coreArray

`default_nettype wire

/* design/sbusResult.sv */
/*
 * Shared data bus driver
 * Phase gating of acknowledges, word select with zeroing, parity
 */
`timescale 1ns/1ns
`default_nettype none

module sbusResult (
  input  wire logic                           sbusClkInt,
  input  wire logic                           rawAckA,
  input  wire logic                           rawAckB,
  input  wire logic [sbusPkg::wordBits-1:0]   wordA,
  input  wire logic [sbusPkg::wordBits-1:0]   wordB,
  output logic                                ackA,
  output logic                                ackB,
  output logic      [sbusPkg::wordBits-1:0]   d,
  output logic                                dataPar
);

  // A phase while sbusClkInt is low, B phase while it is high
  assign ackA = rawAckA && !sbusClkInt;
  assign ackB = rawAckB &&  sbusClkInt;

  // Acknowledge doubles as data valid, so d is zero without one
  always_comb begin
    if (ackA) begin
      d = wordA;
    end else if (ackB) begin
      d = wordB;
    end else begin
      d = '0;
    end
  end

  assign dataPar = ^d;                           // Odd count of ones gives 1

endmodule : sbusResult

`default_nettype wire

/* design/coreMemory.sv */
/*
 * Core memory top for quadword reads on the two-phase storage bus
 * Two decoders, two sequencers, the array and the bus driver
 */
`timescale 1ns/1ns
`default_nettype none

module coreMemory (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic                                sbusClkInt,
  input  wire logic                                startA,
  input  wire logic                                startB,
  input  wire logic [sbusPkg::adrBits-1:0]         adr,
  input  wire logic [sbusPkg::rqBits-1:0]          rq,
  input  wire logic                                loadEn,
  input  wire logic [coreMemPkg::indexBits-1:0]    loadAddr,
  input  wire logic [sbusPkg::wordBits-1:0]        loadData,
  output logic                                     ackA,
  output logic                                     ackB,
  output logic      [sbusPkg::wordBits-1:0]        d,
  output logic                                     dataPar
);

  // Decoder to sequencer, per phase
  logic                              acceptA;
  logic                              acceptB;
  logic [coreMemPkg::quadBits-1:0]   quadBaseA;
  logic [coreMemPkg::quadBits-1:0]   quadBaseB;
  logic [sbusPkg::offBits-1:0]       startOffA;
  logic [sbusPkg::offBits-1:0]       startOffB;
  logic [sbusPkg::rqBits-1:0]        maskA;
  logic [sbusPkg::rqBits-1:0]        maskB;

  // Sequencer to array and driver
  logic [coreMemPkg::indexBits-1:0]  readIndexA;
  logic [coreMemPkg::indexBits-1:0]  readIndexB;
  logic                              rawAckA;
  logic                              rawAckB;
  logic [sbusPkg::wordBits-1:0]      wordA;
  logic [sbusPkg::wordBits-1:0]      wordB;

  quadDecode #(.servesB(1'b0)) decodeA (        // A phase decode
    .clk       (clk),
    .rst       (rst),
    .sbusClkInt(sbusClkInt),
    .start     (startA),
    .adr       (adr),
    .rq        (rq),
    .accept    (acceptA),
    .quadBase  (quadBaseA),
    .startOff  (startOffA),
    .mask      (maskA)
  );

  quadDecode #(.servesB(1'b1)) decodeB (        // B phase decode
    .clk       (clk),
    .rst       (rst),
    .sbusClkInt(sbusClkInt),
    .start     (startB),
    .adr       (adr),
    .rq        (rq),
    .accept    (acceptB),
    .quadBase  (quadBaseB),
    .startOff  (startOffB),
    .mask      (maskB)
  );

  quadSequencer #(.servesB(1'b0)) seqA (
    .clk       (clk),
    .rst       (rst),
    .sbusClkInt(sbusClkInt),
    .accept    (acceptA),
    .quadBase  (quadBaseA),
    .startOff  (startOffA),
    .mask      (maskA),
    .readIndex (readIndexA),
    .rawAck    (rawAckA)
  );

  quadSequencer #(.servesB(1'b1)) seqB (
    .clk       (clk),
    .rst       (rst),
    .sbusClkInt(sbusClkInt),
    .accept    (acceptB),
    .quadBase  (quadBaseB),
    .startOff  (startOffB),
    .mask      (maskB),
    .readIndex (readIndexB),
    .rawAck    (rawAckB)
  );

  coreArray array (
    .clk       (clk),
    .readIndexA(readIndexA),
    .readIndexB(readIndexB),
    .loadEn    (loadEn),
    .loadAddr  (loadAddr),
    .loadData  (loadData),
    .wordA     (wordA),
    .wordB     (wordB)
  );

  sbusResult result (                            // Shared bus outputs
    .sbusClkInt(sbusClkInt),
    .rawAckA   (rawAckA),
    .rawAckB   (rawAckB),
    .wordA     (wordA),
    .wordB     (wordB),
    .ackA      (ackA),
    .ackB      (ackB),
    .d         (d),
    .dataPar   (dataPar)
  );

endmodule : coreMemory

`default_nettype wire

/* test/tbClock.sv */
/*
 * Testbench clock generator, 10 ns period
 */
`timescale 1ns/1ns
`default_nettype none

module tbClock (
  output logic clk
);

  localparam int halfPeriod = 5;               // Half of the 10 ns period

  initial begin
    clk = 1'b0;                                // First rising edge at 5 ns
    forever begin
      #(halfPeriod) clk = ~clk;
    end
  end

endmodule : tbClock

`default_nettype wire

/* test/coreMemory_properties.sv */
/*
 * Bound concurrent checks on phase gating of acknowledges and the idle data bus
 */
`timescale 1ns/1ns
`default_nettype none

module coreMemoryProperties (
  input wire logic                            clk,
  input wire logic                            rst,
  input wire logic                            sbusClkInt,
  input wire logic                            ackA,
  input wire logic                            ackB,
  input wire logic [sbusPkg::wordBits-1:0]    d
);

  // A acknowledge only while sbusClkInt is low
  ackAPhase: assert property (@(posedge clk) disable iff (rst) sbusClkInt |-> !ackA)
    else $error("ackA high during a B cycle");

  // B acknowledge only while sbusClkInt is high
  ackBPhase: assert property (@(posedge clk) disable iff (rst) !sbusClkInt |-> !ackB)
    else $error("ackB high during an A cycle");

  // Acknowledge doubles as data valid, so the bus idles at zero
  idleBus: assert property (@(posedge clk) disable iff (rst) !(ackA || ackB) |-> (d == '0))
    else $error("d not zero while no acknowledge is high");

endmodule : coreMemoryProperties

bind coreMemory coreMemoryProperties props (
  .clk       (clk),
  .rst       (rst),
  .sbusClkInt(sbusClkInt),
  .ackA      (ackA),
  .ackB      (ackB),
  .d         (d)
);

`default_nettype wire

/* test/coreMemoryTb.sv */
/*
 * Core memory testbench with preload, random quadword reads and a cycle model
 * Watchdog and closing summary
 */
`timescale 1ns/1ns
`default_nettype none

module coreMemoryTb;

  localparam int preloadCycles = coreMemPkg::memWords;  // One load per word
  localparam int randomCycles  = 3000;
  localparam int marginCycles  = 200;
  localparam int periodNs      = 10;
  localparam int watchdogNs    = (2 + preloadCycles + randomCycles + marginCycles) * periodNs;

  logic                              clk;
  logic                              rst;
  logic                              sbusClkInt;       // Low is A phase, high is B phase
  logic                              startA;
  logic                              startB;
  logic [sbusPkg::adrBits-1:0]       adr;
  logic [sbusPkg::rqBits-1:0]        rq;
  logic                              loadEn;
  logic [coreMemPkg::indexBits-1:0]  loadAddr;
  logic [sbusPkg::wordBits-1:0]      loadData;
  logic                              ackA;
  logic                              ackB;
  logic [sbusPkg::wordBits-1:0]      d;
  logic                              dataPar;

  // Reference model, indexed by phase (0 is A, 1 is B)
  logic [sbusPkg::wordBits-1:0]      model [coreMemPkg::memWords];
  logic                              reqValid [2];     // Phase has seen an accepted START
  int                                reqCycle [2];     // Cycle of the last accepted START
  logic [coreMemPkg::indexBits-1:0]  reqQuad [2];      // Index of word 0 of the quadword
  logic [sbusPkg::offBits-1:0]       reqOff [2];
  logic [sbusPkg::rqBits-1:0]        reqMask [2];

  integer seed;
  int     errorCount;
  int     checkCount;
  int     cycle;                                       // Cycles since reset release
  int     ackSeen [2];

  tbClock clockGen (.clk(clk));

  coreMemory u_dut (
    .clk       (clk),
    .rst       (rst),
    .sbusClkInt(sbusClkInt),
    .startA    (startA),
    .startB    (startB),
    .adr       (adr),
    .rq        (rq),
    .loadEn    (loadEn),
    .loadAddr  (loadAddr),
    .loadData  (loadData),
    .ackA      (ackA),
    .ackB      (ackB),
    .d         (d),
    .dataPar   (dataPar)
  );

  task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Random 36 bit word from two draws
  task automatic randWord(output logic [sbusPkg::wordBits-1:0] w);
    logic [31:0] lo;
    logic [31:0] hi;
    logic [63:0] both;
    lo   = $random(seed);
    hi   = $random(seed);
    both = {hi, lo};
    w    = both[sbusPkg::wordBits-1:0];
  endtask

  // Stimulus for one random cycle, set at edge plus 1 ns
  task automatic driveRandom();
    logic                         ownStart;
    logic                         wrongStart;
    logic [sbusPkg::wordBits-1:0] w;
    ownStart   = (($random(seed) & 3) == 0);     // One quarter on the own phase
    wrongStart = (($random(seed) & 15) == 0);    // Occasional START on the wrong phase
    if (sbusClkInt) begin
      startB = ownStart;
      startA = wrongStart;
    end else begin
      startA = ownStart;
      startB = wrongStart;
    end
    if (($random(seed) & 7) == 0) begin          // Nonexistent memory
      adr = coreMemPkg::memWords +
            ({$random(seed)} % ((1 << sbusPkg::adrBits) - coreMemPkg::memWords));
    end else begin
      adr = {$random(seed)} % coreMemPkg::memWords;
    end
    if (($random(seed) & 3) == 0) begin
      rq = '1;                                   // Full quadword
    end else begin
      rq = $random(seed);
    end
    if (($random(seed) & 7) == 0) begin          // Load port traffic during reads
      loadEn   = 1'b1;
      loadAddr = $random(seed);
      randWord(w);
      loadData = w;
    end
  endtask

  // Predict and check the current cycle, update the model, step to the next cycle
  task automatic finishCycle();
    int                               ph;
    int                               delta;
    int                               pos;
    logic                             expAck;
    logic [sbusPkg::wordBits-1:0]     expD;
    logic [coreMemPkg::indexBits-1:0] idx;
    logic                             ownStart;
    ph     = sbusClkInt;
    expAck = 1'b0;
    expD   = '0;
    #5;                                          // Outputs settled, well before the edge
    if (reqValid[ph]) begin
      delta = cycle - reqCycle[ph];
      pos   = (delta - 2) / 2;                   // Mask position of this phase cycle
      if (delta >= 2 && pos < sbusPkg::rqBits) begin
        if (reqMask[ph][pos]) begin
          idx    = reqQuad[ph] + ((reqOff[ph] + pos) % sbusPkg::rqBits);
          expAck = 1'b1;
          expD   = model[idx];
        end
      end
    end
    checkValue(ackA, (ph == 0) && expAck, "ackA");
    checkValue(ackB, (ph == 1) && expAck, "ackB");
    checkValue(d, expD, "d");
    checkValue(dataPar, ^expD, "dataPar");
    if (expAck) begin
      ackSeen[ph]++;
    end
    ownStart = (ph == 0) ? startA : startB;
    if (ownStart && adr < coreMemPkg::memWords) begin
      reqValid[ph] = 1'b1;                       // Restarts any pending sequence
      reqCycle[ph] = cycle;
      idx          = adr[coreMemPkg::indexBits-1:0];
      reqOff[ph]   = idx % sbusPkg::rqBits;
      reqQuad[ph]  = idx - (idx % sbusPkg::rqBits);
      reqMask[ph]  = rq;
    end
    if (loadEn) begin
      model[loadAddr] = loadData;                // Visible from the next cycle on
    end
    @(posedge clk);
    #1;
    cycle++;
    sbusClkInt = ~sbusClkInt;                    // Phase alternates every clock
    startA     = 1'b0;
    startB     = 1'b0;
    loadEn     = 1'b0;
  endtask

  initial begin
    logic [sbusPkg::wordBits-1:0] word;
    seed       = 36542;
    errorCount = 0;
    checkCount = 0;
    cycle      = 0;
    ackSeen[0] = 0;
    ackSeen[1] = 0;
    reqValid[0] = 1'b0;
    reqValid[1] = 1'b0;
    rst        = 1'b1;
    sbusClkInt = 1'b0;
    startA     = 1'b0;
    startB     = 1'b0;
    adr        = '0;
    rq         = '0;
    loadEn     = 1'b0;
    loadAddr   = '0;
    loadData   = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;                                  // First cycle is an A cycle

    // Preload every word, outputs stay idle with no START
    for (int i = 0; i < preloadCycles; i++) begin
      loadEn   = 1'b1;
      loadAddr = i;
      randWord(word);
      loadData = word;
      finishCycle();
    end

    for (int i = 0; i < randomCycles; i++) begin
      driveRandom();
      finishCycle();
    end

    if (ackSeen[0] == 0 || ackSeen[1] == 0) begin
      errorCount++;
      $display("No acknowledge was seen on one of the two phases");
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdogNs);
    $display("The run timed out after %0d ns", watchdogNs);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : coreMemoryTb

`default_nettype wire

/* verilog.f */
design/sbusPkg.sv
design/coreMemPkg.sv
design/quadDecode.sv
design/quadSequencer.sv
design/coreArray.sv
design/sbusResult.sv
design/coreMemory.sv
test/tbClock.sv
test/coreMemory_properties.sv
test/coreMemoryTb.sv
